// File: files.f
ldqPkg.sv
ldqInputReg.sv
ldqEntry.sv
ldqAllocator.sv
ldqRetireOut.sv
ldqTop.sv
ldqTb.sv

// File: ldqAllocator.sv
`timescale 1ns/1ps
`default_nettype none

module ldqAllocator (
  input  wire                              clk,
  input  wire                              rst,
  input  wire                              except,
  input  wire                              allocEn,
  input  wire [ldqPkg::ENTRY_COUNT-1:0]    busyVec,
  input  wire [ldqPkg::ENTRY_COUNT-1:0]    retireHitVec,
  output logic [ldqPkg::ENTRY_COUNT-1:0]   allocSel,
  output logic                             doStall
);

  logic [ldqPkg::ENTRY_COUNT-1:0] freeVec;
  logic [ldqPkg::ENTRY_COUNT-1:0] lowestFree;
  logic [ldqPkg::CNT_W-1:0] count;
  logic accept;
  logic retireAny;

  // isolate the lowest set bit of the free vector
  assign freeVec = ~busyVec;
  assign lowestFree = freeVec & (~freeVec + 1'b1);

  assign allocSel = (allocEn && !doStall) ? lowestFree : '0;
  assign accept = |allocSel;
  assign retireAny = |retireHitVec;

  assign doStall = count >= ldqPkg::STALL_LEVEL;

  always_ff @(posedge clk) begin
    if (rst || except) begin
      count <= '0;
    end else begin
      case ({accept, retireAny})
        2'b10: begin
          count <= count + 1'b1;
        end
        2'b01: begin
          count <= count - 1'b1;
        end
        default: begin
          count <= count;
        end
      endcase
    end
  end

  assert property (@(posedge clk) disable iff (rst) !(allocEn && doStall))
    else $error("allocation requested while stalled");

  // unique IIs among the busy entries
  assert property (@(posedge clk) disable iff (rst) $onehot0(retireHitVec))
    else $error("retire matched more than one entry");

  assert property (@(posedge clk) disable iff (rst) count <= ldqPkg::ENTRY_COUNT)
    else $error("occupancy count out of range");

endmodule

`default_nettype wire

// File: ldqEntry.sv
`timescale 1ns/1ps
`default_nettype none

module ldqEntry (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   except,
  input  wire                   allocSel,
  input  wire ldqPkg::lineAddrT allocAddrE,
  input  wire ldqPkg::lineAddrT allocAddrO,
  input  wire ldqPkg::bankMaskT allocBanks,
  input  wire ldqPkg::blowT     allocBlow,
  input  wire ldqPkg::halvesT   allocHalves,
  input  wire ldqPkg::iiT       allocII,
  input  wire                   chkValid,
  input  wire ldqPkg::checkReqT chkReq,
  input  wire                   snoopValid,
  input  wire ldqPkg::snoopReqT snoopReq,
  input  wire                   retireEn,
  input  wire ldqPkg::iiT       retireII,
  output logic                  busy,
  output logic                  retireHit,
  output logic                  conflFlag,
  output logic                  conflSmpFlag
);

  ldqPkg::lineAddrT addrE;
  ldqPkg::lineAddrT addrO;
  ldqPkg::bankMaskT banks;
  ldqPkg::blowT     blow;
  ldqPkg::halvesT   halves;
  ldqPkg::iiT       ii;

  ldqPkg::bankMaskT bankOverlap;
  logic bankLow;
  logic bankHigh;
  logic matchE;
  logic matchO;
  logic blowHit;
  logic chkHit;
  logic anyLow;
  logic anyHigh;
  logic snoopOddHit;
  logic snoopEvenHit;
  logic snoopHit;

  // store check against the held load
  assign bankOverlap = banks & chkReq.banks;
  assign bankLow = |bankOverlap[ldqPkg::BANK_COUNT/2-1:0];
  assign bankHigh = |bankOverlap[ldqPkg::BANK_COUNT-1:ldqPkg::BANK_COUNT/2];
  assign matchE = chkReq.addrE == addrE;
  assign matchO = chkReq.addrO == addrO;
  assign blowHit = |(blow & chkReq.blow);

  assign chkHit = busy && chkValid && blowHit && (
    (halves.oddHigh && chkReq.halves.oddHigh && matchO && bankHigh) ||
    (halves.oddLow && chkReq.halves.oddLow && matchO && bankLow) ||
    (halves.evenHigh && chkReq.halves.evenHigh && matchE && bankHigh) ||
    (halves.evenLow && chkReq.halves.evenLow && matchE && bankLow));

  // snoop covers the whole line, so any bank in a half counts
  assign anyLow = |banks[ldqPkg::BANK_COUNT/2-1:0];
  assign anyHigh = |banks[ldqPkg::BANK_COUNT-1:ldqPkg::BANK_COUNT/2];
  assign snoopOddHit = snoopReq.addr == addrO &&
    ((halves.oddHigh && anyHigh) || (halves.oddLow && anyLow));
  assign snoopEvenHit = snoopReq.addr == addrE &&
    ((halves.evenHigh && anyHigh) || (halves.evenLow && anyLow));
  assign snoopHit = busy && snoopValid && (|blow) &&
    (snoopReq.odd ? snoopOddHit : snoopEvenHit);

  assign retireHit = busy && retireEn && retireII == ii;

  always_ff @(posedge clk) begin
    if (rst) begin
      busy <= 1'b0;
      conflFlag <= 1'b0;
      conflSmpFlag <= 1'b0;
    end else if (except) begin
      busy <= 1'b0;
    end else if (allocSel) begin
      busy <= 1'b1;
      conflFlag <= 1'b0;
      conflSmpFlag <= 1'b0;
    end else begin
      if (retireHit) begin
        busy <= 1'b0;
      end
      // sticky until the next allocation
      conflFlag <= conflFlag | chkHit | snoopHit;
      conflSmpFlag <= conflSmpFlag | snoopHit;
    end
  end

  always_ff @(posedge clk) begin
    if (allocSel) begin
      addrE <= allocAddrE;
      addrO <= allocAddrO;
      banks <= allocBanks;
      blow <= allocBlow;
      halves <= allocHalves;
      ii <= allocII;
    end
  end

  // the allocator only ever picks a free slot
  assert property (@(posedge clk) disable iff (rst) allocSel |-> !busy)
    else $error("allocation into a busy entry");

endmodule

`default_nettype wire

// File: ldqInputReg.sv
`timescale 1ns/1ps
`default_nettype none

module ldqInputReg #(
  parameter type payloadT = logic
) (
  input  wire     clk,
  input  wire     rst,
  input  wire     except,
  input  wire     reqEn,
  input  wire payloadT reqIn,
  output logic    reqValid,
  output payloadT reqOut
);

  // pending request dropped on flush
  always_ff @(posedge clk) begin
    if (rst || except) begin
      reqValid <= 1'b0;
    end else begin
      reqValid <= reqEn;
    end
  end

  always_ff @(posedge clk) begin
    if (reqEn) begin
      reqOut <= reqIn;
    end
  end

  // no stale request may reach the entries right after reset
  assert property (@(posedge clk) rst |=> !reqValid)
    else $error("request valid in the cycle after reset");

endmodule

`default_nettype wire

// File: ldqPkg.sv
`default_nettype none

package ldqPkg;

  localparam int LINE_ADDR_W = 36;
  localparam int BANK_COUNT = 32;
  localparam int BLOW_W = 4;
  localparam int II_W = 10;
  localparam int ENTRY_COUNT = 8;
  localparam int CNT_W = 4;
  localparam int STALL_LEVEL = 7;

  typedef logic [LINE_ADDR_W-1:0] lineAddrT;
  typedef logic [BANK_COUNT-1:0] bankMaskT;
  typedef logic [BLOW_W-1:0] blowT;
  typedef logic [II_W-1:0] iiT;

  // msb first
  typedef struct packed {
    logic oddHigh;
    logic evenHigh;
    logic oddLow;
    logic evenLow;
  } halvesT;

  // store check as seen by every entry
  typedef struct packed {
    lineAddrT addrE;
    lineAddrT addrO;
    bankMaskT banks;
    blowT blow;
    halvesT halves;
  } checkReqT;

  typedef struct packed {
    lineAddrT addr;
    logic odd;
  } snoopReqT;

endpackage

`default_nettype wire

// File: ldqRetireOut.sv
`timescale 1ns/1ps
`default_nettype none

module ldqRetireOut (
  input  wire                           clk,
  input  wire                           rst,
  input  wire                           retireEn,
  input  wire [ldqPkg::ENTRY_COUNT-1:0] retireHitVec,
  input  wire [ldqPkg::ENTRY_COUNT-1:0] conflVec,
  input  wire [ldqPkg::ENTRY_COUNT-1:0] conflSmpVec,
  output logic                          retireDone,
  output logic                          retireHit,
  output logic                          retireConfl,
  output logic                          retireConflSmp
);

  logic hitAny;
  logic conflAny;
  logic conflSmpAny;

  // at most one entry matches, so an OR picks its flags
  assign hitAny = |retireHitVec;
  assign conflAny = |(retireHitVec & conflVec);
  assign conflSmpAny = |(retireHitVec & conflSmpVec);

  always_ff @(posedge clk) begin
    if (rst) begin
      retireDone <= 1'b0;
    end else begin
      retireDone <= retireEn;
    end
  end

  // flags as they stood before the freeing edge
  always_ff @(posedge clk) begin
    retireHit <= hitAny;
    retireConfl <= conflAny;
    retireConflSmp <= conflSmpAny;
  end

endmodule

`default_nettype wire

// File: ldqTb.sv
`timescale 1ns/1ps
`default_nettype none

module ldqTb;

  typedef struct packed {
    logic             allocEn;
    ldqPkg::lineAddrT allocAddrE;
    ldqPkg::lineAddrT allocAddrO;
    ldqPkg::bankMaskT allocBanks;
    ldqPkg::blowT     allocBlow;
    ldqPkg::halvesT   allocHalves;
    ldqPkg::iiT       allocII;
    logic             chkEn;
    ldqPkg::lineAddrT chkAddrE;
    ldqPkg::lineAddrT chkAddrO;
    ldqPkg::bankMaskT chkBanks;
    ldqPkg::blowT     chkBlow;
    ldqPkg::halvesT   chkHalves;
    logic             snoopEn;
    ldqPkg::lineAddrT snoopAddr;
    logic             snoopOdd;
    logic             retireEn;
    ldqPkg::iiT       retireII;
    logic             exceptEn;
    logic             expDone;
    logic             expHit;
    logic             expConfl;
    logic             expSmp;
    logic             expStall;
  } stepT;

  logic clk;
  logic rst;
  logic except;
  logic allocEn;
  ldqPkg::lineAddrT allocAddrE;
  ldqPkg::lineAddrT allocAddrO;
  ldqPkg::bankMaskT allocBanks;
  ldqPkg::blowT allocBlow;
  ldqPkg::halvesT allocHalves;
  ldqPkg::iiT allocII;
  logic chkEn;
  ldqPkg::lineAddrT chkAddrE;
  ldqPkg::lineAddrT chkAddrO;
  ldqPkg::bankMaskT chkBanks;
  ldqPkg::blowT chkBlow;
  ldqPkg::halvesT chkHalves;
  logic snoopEn;
  ldqPkg::lineAddrT snoopAddr;
  logic snoopOdd;
  logic retireEn;
  ldqPkg::iiT retireII;
  wire doStall;
  wire retireDone;
  wire retireHit;
  wire retireConfl;
  wire retireConflSmp;

  stepT steps[$];
  string stepNames[$];
  stepT cur;
  int occ;
  integer seed;
  logic tableReady = 1'b0;
  ldqPkg::lineAddrT loadAddrE [8];
  ldqPkg::lineAddrT loadAddrO [8];

  ldqTop UUT (
    .clk(clk), .rst(rst), .except(except),
    .allocEn(allocEn), .allocAddrE(allocAddrE), .allocAddrO(allocAddrO),
    .allocBanks(allocBanks), .allocBlow(allocBlow), .allocHalves(allocHalves),
    .allocII(allocII),
    .chkEn(chkEn), .chkAddrE(chkAddrE), .chkAddrO(chkAddrO), .chkBanks(chkBanks),
    .chkBlow(chkBlow), .chkHalves(chkHalves),
    .snoopEn(snoopEn), .snoopAddr(snoopAddr), .snoopOdd(snoopOdd),
    .retireEn(retireEn), .retireII(retireII),
    .doStall(doStall), .retireDone(retireDone), .retireHit(retireHit),
    .retireConfl(retireConfl), .retireConflSmp(retireConflSmp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic failRun();
    $display("SOME TESTS FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic checkBit(input int k, input string sigName, input logic expVal,
                          input logic actVal);
    assert (actVal === expVal) else begin
      $display("FAILED %s %s: expected %0b, actual %0b", stepNames[k], sigName, expVal, actVal);
      failRun();
    end
  endtask

  task automatic allocLoad(input int idx, input ldqPkg::iiT ii, input ldqPkg::bankMaskT banks,
                           input ldqPkg::blowT blow, input ldqPkg::halvesT halves);
    cur.allocEn = 1'b1;
    cur.allocAddrE = loadAddrE[idx];
    cur.allocAddrO = loadAddrO[idx];
    cur.allocBanks = banks;
    cur.allocBlow = blow;
    cur.allocHalves = halves;
    cur.allocII = ii;
  endtask

  task automatic storeCheck(input ldqPkg::lineAddrT addrE, input ldqPkg::lineAddrT addrO,
                            input ldqPkg::bankMaskT banks, input ldqPkg::blowT blow,
                            input ldqPkg::halvesT halves);
    cur.chkEn = 1'b1;
    cur.chkAddrE = addrE;
    cur.chkAddrO = addrO;
    cur.chkBanks = banks;
    cur.chkBlow = blow;
    cur.chkHalves = halves;
  endtask

  task automatic snoopLine(input ldqPkg::lineAddrT addr, input logic odd);
    cur.snoopEn = 1'b1;
    cur.snoopAddr = addr;
    cur.snoopOdd = odd;
  endtask

  task automatic retireLoad(input ldqPkg::iiT ii);
    cur.retireEn = 1'b1;
    cur.retireII = ii;
  endtask

  // expected response of this row, occupancy tracked by hand
  task automatic endStep(input string name, input logic hit, input logic confl, input logic smp);
    cur.expDone = cur.retireEn;
    cur.expHit = hit;
    cur.expConfl = confl;
    cur.expSmp = smp;
    if (cur.exceptEn) begin
      occ = 0;
    end else begin
      occ = occ + (cur.allocEn ? 1 : 0) - (hit ? 1 : 0);
    end
    cur.expStall = occ >= ldqPkg::STALL_LEVEL;
    steps.push_back(cur);
    stepNames.push_back(name);
    cur = '0;
  endtask

  task automatic buildTable();
    ldqPkg::lineAddrT noAddr;
    noAddr = 36'hF_0000_0000;
    // top nibble keeps every load's lines distinct
    for (int i = 0; i < 8; i++) begin
      loadAddrE[i] = {4'(i), 32'($random(seed))};
      loadAddrO[i] = {4'(i), 32'($random(seed))};
    end
    cur = '0;
    occ = 0;

    // store hit on the odd line, high banks
    allocLoad(0, 10'd1, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocA", 1'b0, 1'b0, 1'b0);
    storeCheck(noAddr, loadAddrO[0], 32'h0003_0000, 4'b0010, 4'b1000);
    endStep("chkHitA", 1'b0, 1'b0, 1'b0);
    endStep("gapA", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd1);
    endStep("retireA", 1'b1, 1'b1, 1'b0);

    // near misses, one rule broken each
    allocLoad(1, 10'd2, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocB", 1'b0, 1'b0, 1'b0);
    allocLoad(2, 10'd3, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocC", 1'b0, 1'b0, 1'b0);
    allocLoad(3, 10'd4, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocD", 1'b0, 1'b0, 1'b0);
    allocLoad(4, 10'd5, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocE", 1'b0, 1'b0, 1'b0);
    storeCheck(noAddr, loadAddrO[1] ^ 36'h1, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("chkAddrMissB", 1'b0, 1'b0, 1'b0);
    storeCheck(noAddr, loadAddrO[2], 32'h0000_FFFF, 4'b0011, 4'b1000);
    endStep("chkBankMissC", 1'b0, 1'b0, 1'b0);
    storeCheck(noAddr, loadAddrO[3], 32'h0001_0000, 4'b1100, 4'b1000);
    retireLoad(10'd2);
    endStep("chkBlowMissD_retireB", 1'b1, 1'b0, 1'b0);
    storeCheck(noAddr, loadAddrO[4], 32'hFFFF_FFFF, 4'b0011, 4'b0010);
    retireLoad(10'd3);
    endStep("chkHalfMissE_retireC", 1'b1, 1'b0, 1'b0);
    retireLoad(10'd4);
    endStep("retireD", 1'b1, 1'b0, 1'b0);
    retireLoad(10'd5);
    endStep("retireE", 1'b1, 1'b0, 1'b0);

    // snoops on the even line
    allocLoad(5, 10'd6, 32'h0000_0004, 4'b0100, 4'b0001);
    endStep("allocF", 1'b0, 1'b0, 1'b0);
    allocLoad(6, 10'd7, 32'h0000_0004, 4'b0100, 4'b0001);
    endStep("allocG", 1'b0, 1'b0, 1'b0);
    snoopLine(loadAddrE[5], 1'b0);
    endStep("snoopEvenF", 1'b0, 1'b0, 1'b0);
    snoopLine(loadAddrE[6], 1'b1);
    endStep("snoopWrongParityG", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd6);
    endStep("retireF", 1'b1, 1'b1, 1'b1);
    retireLoad(10'd7);
    endStep("retireG", 1'b1, 1'b0, 1'b0);

    retireLoad(10'd500);
    endStep("retireUnknown", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd6);
    endStep("retireAgainF", 1'b0, 1'b0, 1'b0);

    // fill up to the stall level
    for (int i = 0; i < 7; i++) begin
      allocLoad(7, 10'(10 + i), 32'h0001_0000, 4'b0011, 4'b1000);
      endStep($sformatf("fill%0d", i), 1'b0, 1'b0, 1'b0);
    end
    retireLoad(10'd10);
    endStep("retireUnstall", 1'b1, 1'b0, 1'b0);
    allocLoad(7, 10'd17, 32'h0001_0000, 4'b0011, 4'b1000);
    retireLoad(10'd11);
    endStep("allocAndRetire", 1'b1, 1'b0, 1'b0);
    allocLoad(7, 10'd18, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("refill", 1'b0, 1'b0, 1'b0);

    cur.exceptEn = 1'b1;
    endStep("flush", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd12);
    endStep("retireAfterFlush12", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd18);
    endStep("retireAfterFlush18", 1'b0, 1'b0, 1'b0);
    allocLoad(7, 10'd20, 32'h0001_0000, 4'b0011, 4'b1000);
    endStep("allocAfterFlush", 1'b0, 1'b0, 1'b0);
    retireLoad(10'd20);
    endStep("retireAfterFlush20", 1'b1, 1'b0, 1'b0);
    endStep("idle", 1'b0, 1'b0, 1'b0);
  endtask

  task automatic applyStep(input stepT s);
    except = s.exceptEn;
    allocEn = s.allocEn;
    allocAddrE = s.allocAddrE;
    allocAddrO = s.allocAddrO;
    allocBanks = s.allocBanks;
    allocBlow = s.allocBlow;
    allocHalves = s.allocHalves;
    allocII = s.allocII;
    chkEn = s.chkEn;
    chkAddrE = s.chkAddrE;
    chkAddrO = s.chkAddrO;
    chkBanks = s.chkBanks;
    chkBlow = s.chkBlow;
    chkHalves = s.chkHalves;
    snoopEn = s.snoopEn;
    snoopAddr = s.snoopAddr;
    snoopOdd = s.snoopOdd;
    retireEn = s.retireEn;
    retireII = s.retireII;
  endtask

  task automatic checkStep(input int k);
    checkBit(k, "retireDone", steps[k].expDone, retireDone);
    checkBit(k, "retireHit", steps[k].expHit, retireHit);
    checkBit(k, "retireConfl", steps[k].expConfl, retireConfl);
    checkBit(k, "retireConflSmp", steps[k].expSmp, retireConflSmp);
    checkBit(k, "doStall", steps[k].expStall, doStall);
  endtask

  initial begin
    wait (tableReady);
    #((steps.size() + 20) * 100);
    $display("timeout: the step table did not finish in time");
    failRun();
  end

  // rows driven 5 ns after the edge, responses sampled 2 ns after the next one
  initial begin
    seed = 48874;
    rst = 1'b1;
    applyStep('0);
    buildTable();
    tableReady = 1'b1;
    repeat (8) @(posedge clk);
    #5;
    rst = 1'b0;
    for (int k = 0; k < steps.size(); k++) begin
      applyStep(steps[k]);
      @(posedge clk);
      #2;
      checkStep(k);
      #3;
    end
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: ldqTop.sv
`timescale 1ns/1ps
`default_nettype none

module ldqTop (
  input  wire                   clk,
  input  wire                   rst,
  input  wire                   except,
  input  wire                   allocEn,
  input  wire ldqPkg::lineAddrT allocAddrE,
  input  wire ldqPkg::lineAddrT allocAddrO,
  input  wire ldqPkg::bankMaskT allocBanks,
  input  wire ldqPkg::blowT     allocBlow,
  input  wire ldqPkg::halvesT   allocHalves,
  input  wire ldqPkg::iiT       allocII,
  input  wire                   chkEn,
  input  wire ldqPkg::lineAddrT chkAddrE,
  input  wire ldqPkg::lineAddrT chkAddrO,
  input  wire ldqPkg::bankMaskT chkBanks,
  input  wire ldqPkg::blowT     chkBlow,
  input  wire ldqPkg::halvesT   chkHalves,
  input  wire                   snoopEn,
  input  wire ldqPkg::lineAddrT snoopAddr,
  input  wire                   snoopOdd,
  input  wire                   retireEn,
  input  wire ldqPkg::iiT       retireII,
  output wire                   doStall,
  output wire                   retireDone,
  output wire                   retireHit,
  output wire                   retireConfl,
  output wire                   retireConflSmp
);

  wire ldqPkg::checkReqT chkReqIn;
  wire ldqPkg::checkReqT chkReq;
  wire ldqPkg::snoopReqT snoopReqIn;
  wire ldqPkg::snoopReqT snoopReq;
  wire chkValid;
  wire snoopValid;
  wire [ldqPkg::ENTRY_COUNT-1:0] allocSel;
  wire [ldqPkg::ENTRY_COUNT-1:0] busyVec;
  wire [ldqPkg::ENTRY_COUNT-1:0] retireHitVec;
  wire [ldqPkg::ENTRY_COUNT-1:0] conflVec;
  wire [ldqPkg::ENTRY_COUNT-1:0] conflSmpVec;

  assign chkReqIn = '{addrE: chkAddrE, addrO: chkAddrO, banks: chkBanks,
                      blow: chkBlow, halves: chkHalves};
  assign snoopReqIn = '{addr: snoopAddr, odd: snoopOdd};

  ldqInputReg #(.payloadT(ldqPkg::checkReqT)) chkReg (
    .clk(clk), .rst(rst), .except(except),
    .reqEn(chkEn), .reqIn(chkReqIn),
    .reqValid(chkValid), .reqOut(chkReq)
  );

  ldqInputReg #(.payloadT(ldqPkg::snoopReqT)) snoopReg (
    .clk(clk), .rst(rst), .except(except),
    .reqEn(snoopEn), .reqIn(snoopReqIn),
    .reqValid(snoopValid), .reqOut(snoopReq)
  );

  for (genvar i = 0; i < ldqPkg::ENTRY_COUNT; i++) begin : gEntry
    ldqEntry entry (
      .clk(clk), .rst(rst), .except(except),
      .allocSel(allocSel[i]),
      .allocAddrE(allocAddrE), .allocAddrO(allocAddrO), .allocBanks(allocBanks),
      .allocBlow(allocBlow), .allocHalves(allocHalves), .allocII(allocII),
      .chkValid(chkValid), .chkReq(chkReq),
      .snoopValid(snoopValid), .snoopReq(snoopReq),
      .retireEn(retireEn), .retireII(retireII),
      .busy(busyVec[i]), .retireHit(retireHitVec[i]),
      .conflFlag(conflVec[i]), .conflSmpFlag(conflSmpVec[i])
    );
  end

  ldqAllocator allocator (
    .clk(clk), .rst(rst), .except(except), .allocEn(allocEn),
    .busyVec(busyVec), .retireHitVec(retireHitVec),
    .allocSel(allocSel), .doStall(doStall)
  );

  ldqRetireOut retireOut (
    .clk(clk), .rst(rst), .retireEn(retireEn),
    .retireHitVec(retireHitVec), .conflVec(conflVec), .conflSmpVec(conflSmpVec),
    .retireDone(retireDone), .retireHit(retireHit),
    .retireConfl(retireConfl), .retireConflSmp(retireConflSmp)
  );

endmodule

`default_nettype wire

// File: runSim.sh
#!/usr/bin/env bash
# build and run the load queue testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log

verilator --binary --timing --assert -Wno-fatal --top-module ldqTb -f files.f \
  -o ldqSim > build.log 2>&1 \
  || { echo "build failed, see build.log"; cat build.log; exit 1; }

./obj_dir/ldqSim 2>&1 | tee sim.log

grep -q "SOME TESTS FAILED" sim.log && { echo "simulation failed"; exit 1; }
grep -q "ALL TESTS PASSED" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
